// File: project.f
common/usbTxPkg.sv
txPath/crc16Engine.sv
txPath/lineEncoder.sv
txPath/packetSerializer.sv
verilog/requestQueue.sv
verilog/usbTxTop.sv
sim/usbTxChecks_sva.sv
sim/usbTxTb.sv

// File: run.sh
#!/bin/bash
# Build the USB transmit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module usbTxTb \
  -f project.f -Mdir obj_dir -o usbTxSim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/usbTxSim > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

// File: sim/usbTxTb.sv
`timescale 1ns/100ps

module usbTxTb;
  import usbTxPkg::*;

  localparam int numRequests = 40;
  localparam int timeoutCycles = numRequests * 130 + 200;

  logic clock;
  logic reset_n;
  logic reqValid;
  packetKind_t reqKind;
  payload_t reqData;
  logic creditReturn;
  logic dp;
  logic dm;
  logic lineActive;

  logic [31:0] lfsrState = 32'hcf492220;
  int spent = 0;
  int creditsBack = 0;
  int packetsDone = 0;
  int cycles = 0;
  logic awaitFall = 1'b0;
  packetKind_t sentKind[$];
  payload_t sentData[$];
  lineState_t expLine[$];

  usbTxTop UUT (
    .clock, .reset_n, .reqValid, .reqKind, .reqData,
    .creditReturn, .dp, .dm, .lineActive
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and failure handling
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic randBit();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return lsb;
  endfunction

  function automatic packetKind_t drawKind();
    logic [1:0] pick;
    pick[1] = randBit();
    pick[0] = randBit();
    case (pick)
      2'd1:    return ACK;
      2'd2:    return NAK;
      default: return DATA0;
    endcase
  endfunction

  // Two draws per bit bias the payload toward ones
  function automatic payload_t drawPayload();
    payload_t data;
    logic first;
    logic second;
    for (int i = 0; i < payloadBits; i++) begin
      first = randBit();
      second = randBit();
      data[i] = first | second;
    end
    return data;
  endfunction

  task automatic endInFailure();
    $display("sim failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic checkLine(input lineState_t actual, input lineState_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t: line shows %s, expected %s", $time, actual.name(),
        expected.name());
      endInFailure();
    end
  endtask

  task automatic checkCredits(input int count);
    if (count < 0 || count > queueDepth) begin
      $display("** Error at %0t: credit count %0d outside 0..%0d", $time, count,
        queueDepth);
      endInFailure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the line waveform
  ////////////////////////////////////////////////////////////////////////////

  task automatic buildExpected(input packetKind_t kind, input payload_t data);
    logic rawBits[$];
    logic lineBits[$];
    logic [7:0] pid;
    crc16_t crcReg;
    logic feedback;
    int ones;
    logic levelJ;
    expLine.delete();
    pid = (kind == DATA0) ? pidData0 : (kind == ACK) ? pidAck : pidNak;
    for (int i = 0; i < 8; i++) begin
      rawBits.push_back(syncPattern[i]);
    end
    for (int i = 0; i < 8; i++) begin
      rawBits.push_back(pid[i]);
    end
    if (kind == DATA0) begin
      crcReg = crcInit;
      for (int i = 0; i < payloadBits; i++) begin
        rawBits.push_back(data[i]);
        feedback = data[i] ^ crcReg[crcBits-1];
        crcReg = {crcReg[crcBits-2:0], 1'b0};
        if (feedback) begin
          crcReg = crcReg ^ crcPolynomial;
        end
      end
      for (int i = crcBits - 1; i >= 0; i--) begin
        rawBits.push_back(~crcReg[i]);
      end
    end
    // Zero after every run of six ones including a trailing run
    ones = 0;
    for (int i = 0; i < rawBits.size(); i++) begin
      lineBits.push_back(rawBits[i]);
      ones = rawBits[i] ? ones + 1 : 0;
      if (ones == stuffRunLength) begin
        lineBits.push_back(1'b0);
        ones = 0;
      end
    end
    levelJ = 1'b1;
    for (int i = 0; i < lineBits.size(); i++) begin
      if (!lineBits[i]) begin
        levelJ = !levelJ;
      end
      if (levelJ) begin
        expLine.push_back(J);
      end else begin
        expLine.push_back(K);
      end
    end
    for (int i = 0; i < eopSe0Cycles; i++) begin
      expLine.push_back(SE0);
    end
    expLine.push_back(J);
  endtask

  // Line and credits sampled at the falling edge
  always @(negedge clock) begin
    if (reset_n) begin
      checkCredits(queueDepth - spent + creditsBack);
      if (expLine.size() == 0 && !awaitFall && lineActive) begin
        if (sentKind.size() == 0) begin
          $display("line went active with no request outstanding");
          endInFailure();
        end
        buildExpected(sentKind.pop_front(), sentData.pop_front());
      end
      if (expLine.size() > 0) begin
        if (!lineActive) begin
          $display("lineActive fell before the packet was complete");
          endInFailure();
        end
        checkLine(lineState_t'({dp, dm}), expLine.pop_front());
        awaitFall = (expLine.size() == 0);
      end else if (awaitFall) begin
        if (lineActive) begin
          $display("lineActive stayed high after the EOP J cycle");
          endInFailure();
        end
        checkLine(lineState_t'({dp, dm}), J);
        awaitFall = 1'b0;
        packetsDone++;
      end else begin
        checkLine(lineState_t'({dp, dm}), J);
      end
    end
  end

  always @(posedge clock) begin
    if (creditReturn) begin
      creditsBack <= creditsBack + 1;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("timeout: packets did not finish");
      endInFailure();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    packetKind_t kind;
    payload_t data;
    logic [2:0] gap;
    reset_n = 1'b0;
    reqValid = 1'b0;
    reqKind = DATA0;
    reqData = '0;
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    if (lineActive || creditReturn) begin
      $display("lineActive or creditReturn high right after reset");
      endInFailure();
    end
    for (int n = 0; n < numRequests; n++) begin
      kind = drawKind();
      data = drawPayload();
      gap = {randBit(), randBit(), randBit()};
      @(posedge clock);
      while (queueDepth - spent + creditsBack <= 0) begin
        @(posedge clock);
      end
      reqValid <= 1'b1;
      reqKind <= kind;
      reqData <= data;
      spent++;
      sentKind.push_back(kind);
      sentData.push_back(data);
      @(posedge clock);
      reqValid <= 1'b0;
      repeat (gap) @(posedge clock);
    end
    while (packetsDone < numRequests) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    if (creditsBack != numRequests || queueDepth - spent + creditsBack != queueDepth) begin
      $display("credits not all returned: %0d of %0d", creditsBack, numRequests);
      endInFailure();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule : usbTxTb

// File: sim/usbTxChecks_sva.sv
`timescale 1ns/100ps

module usbTxChecks (
  input logic                                           clock,
  input logic                                           reset_n,
  input logic [$clog2(usbTxPkg::queueDepth + 1) - 1:0] occupancy,
  input logic                                           headTake,
  input logic                                           dp,
  input logic                                           dm,
  input logic                                           lineActive
);
  import usbTxPkg::*;

  occupancyBound: assert property (@(posedge clock) disable iff (!reset_n)
    int'(occupancy) <= queueDepth)
    else $error("queue occupancy above its depth");

  // Serializer must not pull from an empty queue
  takeWhileEmpty: assert property (@(posedge clock) disable iff (!reset_n)
    headTake |-> occupancy != '0)
    else $error("headTake while the queue is empty");

  lineLegal: assert property (@(posedge clock) disable iff (!reset_n)
    lineActive |-> !(dp && dm))
    else $error("dp and dm both high on an active line");

endmodule : usbTxChecks

bind requestQueue usbTxChecks queueChecks (
  .clock,
  .reset_n,
  .occupancy,
  .headTake,
  .dp(1'b0),
  .dm(1'b0),
  .lineActive(1'b0)
);

bind lineEncoder usbTxChecks encoderChecks (
  .clock,
  .reset_n,
  .occupancy('0),
  .headTake(1'b0),
  .dp,
  .dm,
  .lineActive
);

// File: verilog/usbTxTop.sv
`timescale 1ns/100ps

module usbTxTop (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  reqValid,
  input  usbTxPkg::packetKind_t reqKind,
  input  usbTxPkg::payload_t    reqData,
  output logic                  creditReturn,
  output logic                  dp,
  output logic                  dm,
  output logic                  lineActive
);
  import usbTxPkg::*;

  logic headValid;
  logic headTake;
  packetKind_t headKind;
  payload_t headData;

  logic crcClear;
  logic crcShift;
  logic crcBit;
  crc16_t crc;

  logic stuffHold;
  logic txBit;
  logic bitValid;
  logic sendSe0;
  logic sendIdleJ;

  requestQueue queue (
    .clock, .reset_n, .reqValid, .reqKind, .reqData,
    .headTake, .headValid, .headKind, .headData, .creditReturn
  );

  packetSerializer serializer (
    .clock, .reset_n, .headValid, .headKind, .headData, .headTake,
    .crc, .crcClear, .crcShift, .crcBit,
    .stuffHold, .txBit, .bitValid, .sendSe0, .sendIdleJ
  );

  crc16Engine crcGen (
    .clock, .reset_n, .crcClear, .crcShift, .crcBit, .crc
  );

  lineEncoder encoder (
    .clock, .reset_n, .txBit, .bitValid, .sendSe0, .sendIdleJ,
    .stuffHold, .dp, .dm, .lineActive
  );

endmodule : usbTxTop

// File: verilog/requestQueue.sv
`timescale 1ns/100ps

module requestQueue (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  reqValid,
  input  usbTxPkg::packetKind_t reqKind,
  input  usbTxPkg::payload_t    reqData,
  input  logic                  headTake,
  output logic                  headValid,
  output usbTxPkg::packetKind_t headKind,
  output usbTxPkg::payload_t    headData,
  output logic                  creditReturn
);
  import usbTxPkg::*;

  localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntBits = $clog2(queueDepth + 1);
  localparam logic [ptrBits-1:0] lastSlot = ptrBits'(queueDepth - 1);

  packetKind_t kindMem [queueDepth];
  payload_t dataMem [queueDepth];

  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] occupancy;

  assign headValid = (occupancy != '0);
  assign headKind = kindMem[rdPtr];
  assign headData = dataMem[rdPtr];

  always_ff @(posedge clock) begin
    if (reqValid) begin
      kindMem[wrPtr] <= reqKind;
      dataMem[wrPtr] <= reqData;
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      occupancy <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (reqValid) begin
        wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + ptrBits'(1);
      end
      if (headTake) begin
        rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + ptrBits'(1);
      end
      // Upstream owns the freed slot one cycle after the take
      creditReturn <= headTake;
      if (reqValid && !headTake) begin
        occupancy <= occupancy + cntBits'(1);
      end else if (!reqValid && headTake) begin
        occupancy <= occupancy - cntBits'(1);
      end
    end
  end

endmodule : requestQueue

// File: txPath/packetSerializer.sv
`timescale 1ns/100ps

module packetSerializer (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  headValid,
  input  usbTxPkg::packetKind_t headKind,
  input  usbTxPkg::payload_t    headData,
  output logic                  headTake,
  input  usbTxPkg::crc16_t      crc,
  output logic                  crcClear,
  output logic                  crcShift,
  output logic                  crcBit,
  input  logic                  stuffHold,
  output logic                  txBit,
  output logic                  bitValid,
  output logic                  sendSe0,
  output logic                  sendIdleJ
);
  import usbTxPkg::*;

  localparam int idxBits = $clog2(payloadBits);
  localparam int crcIdxBits = $clog2(crcBits);
  localparam logic [idxBits-1:0] lastByteBit = idxBits'(7);
  localparam logic [idxBits-1:0] lastPayloadBit = idxBits'(payloadBits - 1);
  localparam logic [idxBits-1:0] lastCrcBit = idxBits'(crcBits - 1);
  localparam logic [idxBits-1:0] eopJIndex = idxBits'(eopSe0Cycles);

  typedef enum logic [2:0] {Idle, Sync, Pid, Payload, Crc, Eop} phase_t;

  phase_t phase;
  logic [idxBits-1:0] bitIndex;
  logic [crcIdxBits-1:0] crcIndex;
  packetKind_t kindReg;
  payload_t dataReg;
  logic [7:0] pidByte;
  logic lastBit;

  assign headTake = (phase == Idle) && headValid;
  assign crcClear = headTake;
  assign crcShift = (phase == Payload) && !stuffHold;
  assign crcBit = dataReg[bitIndex];

  // CRC goes out MSB first
  assign crcIndex = crcIdxBits'(crcBits - 1) - bitIndex[crcIdxBits-1:0];

  always_comb begin
    case (kindReg)
      DATA0:   pidByte = pidData0;
      ACK:     pidByte = pidAck;
      default: pidByte = pidNak;
    endcase
  end

  always_comb begin
    case (phase)
      Sync, Pid: lastBit = (bitIndex == lastByteBit);
      Payload:   lastBit = (bitIndex == lastPayloadBit);
      Crc:       lastBit = (bitIndex == lastCrcBit);
      Eop:       lastBit = (bitIndex == eopJIndex);
      default:   lastBit = 1'b0;
    endcase
  end

  always_comb begin
    txBit = 1'b0;
    bitValid = 1'b0;
    sendSe0 = 1'b0;
    sendIdleJ = 1'b0;
    case (phase)
      Sync: begin
        txBit = syncPattern[bitIndex[2:0]];
        bitValid = 1'b1;
      end
      Pid: begin
        txBit = pidByte[bitIndex[2:0]];
        bitValid = 1'b1;
      end
      Payload: begin
        txBit = dataReg[bitIndex];
        bitValid = 1'b1;
      end
      Crc: begin
        txBit = ~crc[crcIndex];
        bitValid = 1'b1;
      end
      Eop: begin
        sendSe0 = (bitIndex < eopJIndex);
        sendIdleJ = (bitIndex == eopJIndex);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (headTake) begin
      kindReg <= headKind;
      dataReg <= headData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase sequencing frozen while the encoder inserts a stuffed zero
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      phase <= Idle;
      bitIndex <= '0;
    end else if (headTake) begin
      phase <= Sync;
      bitIndex <= '0;
    end else if (phase != Idle && !stuffHold) begin
      if (!lastBit) begin
        bitIndex <= bitIndex + idxBits'(1);
      end else begin
        bitIndex <= '0;
        case (phase)
          Sync:    phase <= Pid;
          Pid:     phase <= (kindReg == DATA0) ? Payload : Eop;
          Payload: phase <= Crc;
          Crc:     phase <= Eop;
          default: phase <= Idle;
        endcase
      end
    end
  end

endmodule : packetSerializer

// File: txPath/lineEncoder.sv
`timescale 1ns/100ps

module lineEncoder (
  input  logic clock,
  input  logic reset_n,
  input  logic txBit,
  input  logic bitValid,
  input  logic sendSe0,
  input  logic sendIdleJ,
  output logic stuffHold,
  output logic dp,
  output logic dm,
  output logic lineActive
);
  import usbTxPkg::*;

  localparam int cntBits = $clog2(stuffRunLength + 1);

  logic [cntBits-1:0] onesCount;
  // High while the NRZI level is J
  logic levelJ;
  logic sendZero;
  logic nextLevelJ;
  lineState_t lineNext;

  // Stuffed zero takes priority even over the first EOP cycle
  assign stuffHold = (onesCount == cntBits'(stuffRunLength));
  assign sendZero = stuffHold || (bitValid && !txBit);
  assign nextLevelJ = sendZero ? ~levelJ : levelJ;

  always_comb begin
    if (stuffHold || bitValid) begin
      lineNext = nextLevelJ ? J : K;
    end else if (sendSe0) begin
      lineNext = SE0;
    end else begin
      lineNext = J;
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      onesCount <= '0;
      levelJ <= 1'b1;
      dp <= 1'b1;
      dm <= 1'b0;
      lineActive <= 1'b0;
    end else begin
      {dp, dm} <= lineNext;
      lineActive <= stuffHold || bitValid || sendSe0 || sendIdleJ;
      if (stuffHold || bitValid) begin
        levelJ <= nextLevelJ;
        onesCount <= sendZero ? '0 : onesCount + cntBits'(1);
      end else begin
        // NRZI returns to J at the EOP J cycle
        onesCount <= '0;
        if (sendIdleJ) begin
          levelJ <= 1'b1;
        end
      end
    end
  end

endmodule : lineEncoder

// File: txPath/crc16Engine.sv
`timescale 1ns/100ps

module crc16Engine (
  input  logic             clock,
  input  logic             reset_n,
  input  logic             crcClear,
  input  logic             crcShift,
  input  logic             crcBit,
  output usbTxPkg::crc16_t crc
);
  import usbTxPkg::*;

  logic feedback;

  assign feedback = crcBit ^ crc[crcBits-1];

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      crc <= crcInit;
    end else if (crcClear) begin
      crc <= crcInit;
    end else if (crcShift) begin
      if (feedback) begin
        crc <= {crc[crcBits-2:0], 1'b0} ^ crcPolynomial;
      end else begin
        crc <= {crc[crcBits-2:0], 1'b0};
      end
    end
  end

endmodule : crc16Engine

// File: common/usbTxPkg.sv
package usbTxPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Request and line types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DATA0 = 2'd0,
    ACK   = 2'd1,
    NAK   = 2'd2
  } packetKind_t;

  // Encoded as {dp, dm}
  typedef enum logic [1:0] {
    SE0 = 2'b00,
    K   = 2'b01,
    J   = 2'b10
  } lineState_t;

  typedef logic [63:0] payload_t;
  typedef logic [15:0] crc16_t;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol constants sent LSB first
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] syncPattern = 8'h80;
  localparam logic [7:0] pidData0 = 8'hC3;
  localparam logic [7:0] pidAck = 8'hD2;
  localparam logic [7:0] pidNak = 8'h5A;

  localparam crc16_t crcPolynomial = 16'h8005;
  localparam crc16_t crcInit = 16'hFFFF;

  localparam int stuffRunLength = 6;
  localparam int eopSe0Cycles = 2;
  localparam int queueDepth = 2;
  localparam int payloadBits = 64;
  localparam int crcBits = 16;

endpackage : usbTxPkg
